//--- include/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Character format, 8N1 on the line
`define UART_DATA_BITS      8

// Receiver samples each bit this many times
`define UART_OVERSAMPLE     16

// System clocks per oversample tick, one bit is 64 clocks
`define UART_CLKS_PER_TICK  4

// Buffering on both sides
`define UART_FIFO_DEPTH     8
`define UART_FIFO_AFULL     7   // almost_full threshold in entries

`endif

//--- rtl/uart_pkg.sv
`include "uart_macros.svh"

package uart_pkg;

    // One character as written by the host
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // What the receiver hands to the RX FIFO
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // Stop bit sampled low
    } rx_frame_t;

    // Flags returned from each FIFO
    typedef struct packed {
        logic full;
        logic empty;
        logic almost_full;
        logic overflow;     // Write refused last cycle
        logic underflow;    // Read refused last cycle
    } fifo_status_t;

endpackage

//--- rtl/sync_fifo.sv
`timescale 1ns/100ps
`include "uart_macros.svh"

module sync_fifo
    import uart_pkg::*;
#(
    parameter type T           = logic [7:0],
    parameter int  DEPTH       = `UART_FIFO_DEPTH,
    parameter int  AFULL_LEVEL = `UART_FIFO_AFULL
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wr_en,
    input  T             wr_data,
    input  logic         rd_en,
    output T             rd_data,
    output fifo_status_t status
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;   // Must hold DEPTH itself

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             almost_full;
    logic             overflow_q;
    logic             underflow_q;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (count == CNT_W'(DEPTH));
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(AFULL_LEVEL));

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_ptr] <= wr_data;
    end

    // Registered read port, holds its value when nothing is popped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_data <= '0;
        else if (rd_ok)
            rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else begin
            overflow_q  <= wr_en && full;
            underflow_q <= rd_en && empty;
        end
    end

    assign status = '{
        full:        full,
        empty:       empty,
        almost_full: almost_full,
        overflow:    overflow_q,
        underflow:   underflow_q
    };

endmodule

//--- rtl/baud_timer.sv
`timescale 1ns/100ps

module baud_timer #(
    parameter int DIVISOR = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

    logic [CNT_W-1:0] count;

    // Tick is high for the one clock after each wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == CNT_W'(DIVISOR - 1)) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,
    input  logic       fifo_empty,
    input  uart_byte_t fifo_data,
    output logic       fifo_rd_en,
    output logic       txd
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        START,
        DATA,
        STOP
    } state_t;

    state_t            state;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_idx;
    uart_byte_t        shifter;
    logic              bit_end;

    assign fifo_rd_en = (state == IDLE) && !fifo_empty;   // Leaves IDLE next edge
    assign bit_end    = tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;
        end else begin
            if (tick && (state == START || state == DATA || state == STOP))
                tick_cnt <= tick_cnt + 1'b1;    // Wraps to zero at bit end

            case (state)
                IDLE: begin
                    if (fifo_rd_en)
                        state <= FETCH;
                end
                FETCH: begin
                    // Start bit begins on a tick so every bit is 16 whole ticks
                    if (tick) begin
                        txd      <= 1'b0;
                        tick_cnt <= '0;
                        state    <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        txd     <= shifter[0];
                        bit_idx <= '0;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == BIT_W'(`UART_DATA_BITS - 1)) begin
                            txd   <= 1'b1;
                            state <= STOP;
                        end else begin
                            txd     <= shifter[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (bit_end)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Popped byte sits on fifo_data for as long as FETCH waits
    always_ff @(posedge clk) begin
        if (state == FETCH)
            shifter <= fifo_data;
        else if (bit_end && (state == START || state == DATA))
            shifter <= shifter >> 1;    // LSB first
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tick,
    input  logic      rxd,
    output logic      frame_wr_en,
    output rx_frame_t frame
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t            state;
    logic              rxd_meta;
    logic              rxd_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_idx;
    logic              mid_start;
    logic              bit_end;
    logic              sample_data;
    logic              sample_stop;

    // Line idles high, so the synchronizer resets to one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign mid_start   = tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE / 2 - 1));
    assign bit_end     = tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
    assign sample_data = (state == DATA) && bit_end;
    assign sample_stop = (state == STOP) && bit_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            frame_wr_en <= 1'b0;
        end else begin
            frame_wr_en <= 1'b0;
            if (tick && state != IDLE)
                tick_cnt <= tick_cnt + 1'b1;

            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    if (!rxd_sync)
                        state <= START;
                end
                START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;     // Later samples land mid-bit
                        bit_idx  <= '0;
                        state    <= rxd_sync ? IDLE : DATA;     // Glitch, not a start bit
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == BIT_W'(`UART_DATA_BITS - 1))
                            state <= STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        frame_wr_en <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample_data)
            frame.data <= {rxd_sync, frame.data[`UART_DATA_BITS-1:1]};   // LSB arrives first
        if (sample_stop)
            frame.frame_err <= !rxd_sync;
    end

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_top
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tx_wr_en,
    input  uart_byte_t   tx_wr_data,
    output fifo_status_t tx_status,
    input  logic         rx_rd_en,
    output rx_frame_t    rx_rd_data,
    output fifo_status_t rx_status,
    input  logic         rxd,
    output logic         txd
);

    logic       tick;
    logic       tx_fifo_rd_en;
    uart_byte_t tx_fifo_data;
    logic       rx_frame_wr_en;
    rx_frame_t  rx_frame;

    baud_timer #(
        .DIVISOR (`UART_CLKS_PER_TICK)
    ) u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    sync_fifo #(
        .T           (uart_byte_t),
        .DEPTH       (`UART_FIFO_DEPTH),
        .AFULL_LEVEL (`UART_FIFO_AFULL)
    ) u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (tx_wr_en),
        .wr_data (tx_wr_data),
        .rd_en   (tx_fifo_rd_en),
        .rd_data (tx_fifo_data),
        .status  (tx_status)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .fifo_empty (tx_status.empty),
        .fifo_data  (tx_fifo_data),
        .fifo_rd_en (tx_fifo_rd_en),
        .txd        (txd)
    );

    // No back-pressure, a full RX FIFO drops the frame and flags overflow
    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .rxd         (rxd),
        .frame_wr_en (rx_frame_wr_en),
        .frame       (rx_frame)
    );

    sync_fifo #(
        .T           (rx_frame_t),
        .DEPTH       (`UART_FIFO_DEPTH),
        .AFULL_LEVEL (`UART_FIFO_AFULL)
    ) u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rx_frame_wr_en),
        .wr_data (rx_frame),
        .rd_en   (rx_rd_en),
        .rd_data (rx_rd_data),
        .status  (rx_status)
    );

endmodule

//--- verification/tb_uart_top.sv
`timescale 1ns/100ps
`include "uart_macros.svh"

module tb_uart_top
    import uart_pkg::*;
();

    localparam int BIT_CLKS      = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;
    localparam int FRAME_CLKS    = BIT_CLKS * (`UART_DATA_BITS + 2);
    localparam int TOTAL_FRAMES  = 5 + 9 + 9 + 2;
    localparam int WATCHDOG_CLKS = TOTAL_FRAMES * FRAME_CLKS * 12 / 10;
    localparam int DEPTH         = `UART_FIFO_DEPTH;

    localparam fifo_status_t EMPTY_ONLY = '{
        full: 1'b0, empty: 1'b1, almost_full: 1'b0, overflow: 1'b0, underflow: 1'b0
    };

    // Full FIFO that has just refused a write
    localparam fifo_status_t FULL_OVERFLOW = '{
        full: 1'b1, empty: 1'b0, almost_full: 1'b1, overflow: 1'b1, underflow: 1'b0
    };

    logic         clk;
    logic         rst_n;
    logic         tx_wr_en;
    uart_byte_t   tx_wr_data;
    fifo_status_t tx_status;
    logic         rx_rd_en;
    rx_frame_t    rx_rd_data;
    fifo_status_t rx_status;
    logic         rxd;
    logic         txd;

    logic         drive_raw;    // Selects raw_rxd instead of loopback
    logic         raw_rxd;
    logic [31:0]  lfsr_state;
    uart_byte_t   exp_q[$];     // Bytes the host expects back, in order
    int           tx_model_count;
    logic         pop_pending;
    int           tx_ovf_seen;
    int           rx_ovf_seen;
    string        test_name;

    assign rxd = drive_raw ? raw_rxd : txd;

    uart_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_wr_en   (tx_wr_en),
        .tx_wr_data (tx_wr_data),
        .tx_status  (tx_status),
        .rx_rd_en   (rx_rd_en),
        .rx_rd_data (rx_rd_data),
        .rx_status  (rx_status),
        .rxd        (rxd),
        .txd        (txd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic expect_equal(input string what, input int expected, input int actual);
        assert (expected == actual)
        else fail_run($sformatf("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output uart_byte_t b);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    // Transmitter idle and empty, so the first accepted byte is popped at once
    task automatic start_from_idle();
        tx_model_count = 0;
        pop_pending    = 1'b1;
    endtask

    task automatic write_byte(input uart_byte_t b);
        @(negedge clk);
        tx_wr_en   = 1'b1;
        tx_wr_data = b;
        if (tx_model_count < DEPTH) begin
            exp_q.push_back(b);
            tx_model_count++;
            if (pop_pending) begin
                tx_model_count--;
                pop_pending = 1'b0;
            end
        end
    endtask

    task automatic release_write();
        @(negedge clk);
        tx_wr_en = 1'b0;
    endtask

    task automatic wait_rx_data(input int limit);
        int waited;
        waited = 0;
        while (rx_status.empty) begin
            @(negedge clk);
            waited++;
            if (waited > limit)
                fail_run($sformatf("Timed out in %s waiting for a received frame", test_name));
        end
    endtask

    task automatic wait_rx_drop(input int base, input int limit);
        int waited;
        waited = 0;
        while (rx_ovf_seen == base) begin
            @(negedge clk);
            waited++;
            if (waited > limit)
                fail_run($sformatf("Timed out in %s waiting for the RX FIFO to drop a frame",
                                   test_name));
        end
    endtask

    task automatic read_frame(output rx_frame_t f);
        @(negedge clk);
        rx_rd_en = 1'b1;
        @(negedge clk);
        rx_rd_en = 1'b0;
        f        = rx_rd_data;
    endtask

    task automatic receive_expected(input logic exp_err);
        rx_frame_t  f;
        uart_byte_t exp;
        wait_rx_data(2 * FRAME_CLKS);
        read_frame(f);
        exp = exp_q.pop_front();
        expect_equal("data", int'(exp), int'(f.data));
        expect_equal("frame_err", int'(exp_err), int'(f.frame_err));
        expect_equal("underflow", 0, int'(rx_status.underflow));
    endtask

    task automatic send_raw_frame(input uart_byte_t b, input logic stop_bit);
        exp_q.push_back(b);
        @(negedge clk);
        raw_rxd = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            raw_rxd = b[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        raw_rxd = stop_bit;
        repeat (BIT_CLKS * 3 / 4) @(negedge clk);     // Past the mid-bit stop sample
        raw_rxd = 1'b1;
        repeat (BIT_CLKS / 4 + BIT_CLKS) @(negedge clk);
    endtask

    // Lets the stop bit of the last frame finish
    task automatic settle_tx();
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (rst_n && tx_status.overflow)
            tx_ovf_seen = tx_ovf_seen + 1;
        if (rst_n && rx_status.overflow)
            rx_ovf_seen = rx_ovf_seen + 1;
    end

    // Overflow is high for exactly the cycle after a write into a full FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_status.overflow == $past(tx_wr_en && tx_status.full))
    else fail_run("TX overflow flag did not follow a write into a full FIFO");

    assert property (@(posedge clk) disable iff (!rst_n)
        rx_status.underflow == $past(rx_rd_en && rx_status.empty))
    else fail_run("RX underflow flag did not follow a read from an empty FIFO");

    assert property (@(posedge clk) disable iff (!rst_n)
        rx_rd_en && rx_status.empty |=> $stable(rx_rd_data))
    else fail_run("A read from the empty RX FIFO changed rx_rd_data");

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        fail_run($sformatf("Watchdog expired during %s, the run took too long", test_name));
    end

    initial begin
        uart_byte_t b;
        rx_frame_t  f;
        rx_frame_t  held;
        int         ovf_base;
        int         rx_base;
        rst_n          = 1'b0;
        tx_wr_en       = 1'b0;
        tx_wr_data     = '0;
        rx_rd_en       = 1'b0;
        drive_raw      = 1'b0;
        raw_rxd        = 1'b1;
        lfsr_state     = 32'h534;
        tx_model_count = 0;
        pop_pending    = 1'b0;
        tx_ovf_seen    = 0;
        rx_ovf_seen    = 0;
        test_name      = "reset";
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset_state";
        @(negedge clk);
        expect_equal("txd", 1, int'(txd));
        expect_equal("tx_status", int'(EMPTY_ONLY), int'(tx_status));
        expect_equal("rx_status", int'(EMPTY_ONLY), int'(rx_status));
        expect_equal("rx_rd_data", 0, int'(rx_rd_data));

        test_name = "loopback_order";
        start_from_idle();
        for (int i = 0; i < 5; i++) begin
            rand_byte(b);
            write_byte(b);
            release_write();
            rand_byte(b);
            repeat (int'(b[3:0]) + 1) @(negedge clk);    // Random gap
        end
        repeat (5) receive_expected(1'b0);
        settle_tx();

        test_name = "tx_overflow";
        ovf_base  = tx_ovf_seen;
        rx_base   = rx_ovf_seen;
        start_from_idle();
        for (int i = 0; i < 12; i++) begin
            rand_byte(b);
            write_byte(b);
        end
        release_write();
        expect_equal("tx_status", int'(FULL_OVERFLOW), int'(tx_status));
        repeat (9) receive_expected(1'b0);
        expect_equal("tx overflow pulses", 3, tx_ovf_seen - ovf_base);
        expect_equal("rx overflow pulses", 0, rx_ovf_seen - rx_base);
        settle_tx();

        test_name = "rx_overflow_underflow";
        rx_base   = rx_ovf_seen;
        start_from_idle();
        for (int i = 0; i < 9; i++) begin
            rand_byte(b);
            write_byte(b);
        end
        release_write();
        wait_rx_drop(rx_base, 11 * FRAME_CLKS);
        expect_equal("rx full", 1, int'(rx_status.full));
        repeat (8) receive_expected(1'b0);
        b = exp_q.pop_front();      // Ninth frame found the RX FIFO full
        expect_equal("rx overflow pulses", 1, rx_ovf_seen - rx_base);
        expect_equal("rx empty", 1, int'(rx_status.empty));
        held = rx_rd_data;
        read_frame(f);
        expect_equal("underflow", 1, int'(rx_status.underflow));
        expect_equal("held rx_rd_data", int'(held), int'(f));
        settle_tx();

        test_name = "framing_error";
        drive_raw = 1'b1;
        rand_byte(b);
        send_raw_frame(b, 1'b0);
        receive_expected(1'b1);
        rand_byte(b);
        send_raw_frame(b, 1'b1);
        receive_expected(1'b0);
        drive_raw = 1'b0;

        if (rx_status.empty && tx_status.empty) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("A FIFO still held data at the end of the run");
        end
    end

endmodule

//--- files.f
+incdir+include
rtl/uart_pkg.sv
rtl/sync_fifo.sv
rtl/baud_timer.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verification/tb_uart_top.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

TOP=tb_uart_top
OBJ_DIR=obj_dir

if ! verilator --binary --timing --assert --top-module "$TOP" \
        -f files.f -Mdir "$OBJ_DIR" -o "V$TOP"; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$("./$OBJ_DIR/V$TOP" 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
